// ==== hdl/rix_cfg.svh ====
// Build-time configuration of the framebuffer write path
// Memory and command widths, request FIFO depth and the
// limit on memory writes waiting for a response
`ifndef RIX_CFG_SVH
`define RIX_CFG_SVH

// Memory address width in bits
`define RIX_ADDR_WIDTH 32

// Command word and memory data width in bits
`define RIX_DATA_WIDTH 32

// The request FIFO ring holds 2**RIX_FIFO_DEPTH_LG entries
`define RIX_FIFO_DEPTH_LG 3

// Most memory writes that may wait for their response at once
`define RIX_MAX_OUTSTANDING 4

`endif

// ==== hdl/rix_cmd_pkg.sv ====
// Command stream definitions
// Opcodes, the OP_PIXELS count type and the header word layout
package rix_cmd_pkg;

    // Opcode in header bits 31 to 28, unlisted values are ignored
    typedef enum logic [3:0]
    {
        OP_NOP      = 4'd0,
        OP_SET_ADDR = 4'd1,
        OP_PIXELS   = 4'd2,
        OP_COMMIT   = 4'd3
    } cmd_op_t;

    // Number of data words that follow an OP_PIXELS header
    typedef logic [15:0] pixel_count_t;

    // Header word as seen on the command stream
    typedef struct packed
    {
        cmd_op_t      op;
        logic [11:0]  rsvd;
        pixel_count_t count;
    } cmd_header_t;

    // Position of the vsync flag in an OP_COMMIT header
    localparam int VSYNC_BIT = 0;

    // Byte step between two consecutive pixel words in memory
    localparam int PIXEL_STRIDE = 4;

endpackage

// ==== hdl/rix_mem_pkg.sv ====
// Memory side definitions
// Address and data types and the request entry that travels
// from the command parser through the FIFO to the writer
`include "rix_cfg.svh"

package rix_mem_pkg;

    typedef logic [`RIX_ADDR_WIDTH - 1 : 0] mem_addr_t;
    typedef logic [`RIX_DATA_WIDTH - 1 : 0] mem_data_t;

    // One request, either a pixel write or a framebuffer commit.
    // For a commit the address is the framebuffer base.
    typedef struct packed
    {
        logic      commit;
        mem_addr_t addr;
        mem_data_t data;
        logic      vsync;
    } fb_req_t;

endpackage

// ==== hdl/rix_cmd_parser.sv ====
// Command stream parser
// Decodes header, address and pixel words into write requests
// and commit requests for the request FIFO
`timescale 1ns/1ps

module rix_cmd_parser
(
    input  logic                    aclk,
    input  logic                    rst_n,

    input  logic                    s_cmd_tvalid,
    output logic                    s_cmd_tready,
    input  logic                    s_cmd_tlast,
    input  rix_mem_pkg::mem_data_t  s_cmd_tdata,

    input  logic                    req_full,
    output logic                    req_push,
    output logic                    req_commit,
    output rix_mem_pkg::mem_addr_t  req_addr,
    output rix_mem_pkg::mem_data_t  req_data,
    output logic                    req_vsync
);
    typedef enum logic [1:0]
    {
        ST_HEADER,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t                     state;
    logic                       run_q;
    rix_mem_pkg::mem_addr_t     base_q;
    rix_mem_pkg::mem_addr_t     ptr_q;
    rix_cmd_pkg::pixel_count_t  remaining_q;

    rix_cmd_pkg::cmd_header_t   header;
    logic                       need_push;
    logic                       accept;

    assign header = rix_cmd_pkg::cmd_header_t'(s_cmd_tdata);

    // Pixel words and commit headers produce a FIFO entry
    assign need_push = (state == ST_DATA) ||
                       ((state == ST_HEADER) && (header.op == rix_cmd_pkg::OP_COMMIT));

    // Only a word that must be pushed waits for FIFO space
    assign s_cmd_tready = run_q && !(need_push && req_full);
    assign accept       = s_cmd_tvalid && s_cmd_tready;

    assign req_push   = accept && need_push;
    assign req_commit = (state == ST_HEADER);
    assign req_addr   = (state == ST_HEADER) ? base_q : ptr_q;
    assign req_data   = s_cmd_tdata;
    assign req_vsync  = s_cmd_tdata[rix_cmd_pkg::VSYNC_BIT];

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state       <= ST_HEADER;
            run_q       <= 1'b0;
            base_q      <= '0;
            ptr_q       <= '0;
            remaining_q <= '0;
        end
        else
        begin
            // Stream is held off for the first cycle out of reset
            run_q <= 1'b1;

            if (accept)
            begin
                case (state)
                    ST_HEADER:
                    begin
                        if (header.op == rix_cmd_pkg::OP_SET_ADDR)
                        begin
                            state <= ST_ADDR;
                        end
                        else if ((header.op == rix_cmd_pkg::OP_PIXELS) && (header.count != '0))
                        begin
                            state       <= ST_DATA;
                            remaining_q <= header.count;
                        end
                    end
                    ST_ADDR:
                    begin
                        // New base also restarts the pixel pointer
                        base_q <= s_cmd_tdata;
                        ptr_q  <= s_cmd_tdata;
                        state  <= ST_HEADER;
                    end
                    ST_DATA:
                    begin
                        ptr_q       <= ptr_q + rix_mem_pkg::mem_addr_t'(rix_cmd_pkg::PIXEL_STRIDE);
                        remaining_q <= remaining_q - 1'b1;
                        // A tlast cuts the pixel block short
                        if ((remaining_q == 16'd1) || s_cmd_tlast)
                        begin
                            state <= ST_HEADER;
                        end
                    end
                    default:
                    begin
                        state <= ST_HEADER;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/rix_req_fifo.sv ====
// Request FIFO between the command parser and the framebuffer writer
// Ring of fb_req_t entries behind a registered head entry
`timescale 1ns/1ps
`include "rix_cfg.svh"

module rix_req_fifo
(
    input  logic                    aclk,
    input  logic                    rst_n,

    input  logic                    req_push,
    input  logic                    req_commit,
    input  rix_mem_pkg::mem_addr_t  req_addr,
    input  rix_mem_pkg::mem_data_t  req_data,
    input  logic                    req_vsync,
    output logic                    req_full,

    output logic                    req_valid,
    input  logic                    req_pop,
    output logic                    head_commit,
    output rix_mem_pkg::mem_addr_t  head_addr,
    output rix_mem_pkg::mem_data_t  head_data,
    output logic                    head_vsync
);
    localparam int LG    = `RIX_FIFO_DEPTH_LG;
    localparam int DEPTH = 1 << LG;

    rix_mem_pkg::fb_req_t   ring [DEPTH];
    rix_mem_pkg::fb_req_t   push_entry;
    rix_mem_pkg::fb_req_t   head_q;
    logic                   head_valid;
    logic [LG : 0]          wr_ptr;
    logic [LG : 0]          rd_ptr;
    logic                   ring_empty;
    logic                   head_load;
    logic                   bypass;
    logic                   ring_wr;
    logic                   ring_rd;

    assign push_entry = '{commit: req_commit, addr: req_addr, data: req_data, vsync: req_vsync};

    assign ring_empty = (wr_ptr == rd_ptr);
    assign req_full   = (wr_ptr[LG] != rd_ptr[LG]) && (wr_ptr[LG-1:0] == rd_ptr[LG-1:0]);

    // Head takes a new entry when it is empty or being popped.
    // With an empty ring a push goes straight into the head.
    assign head_load = !head_valid || req_pop;
    assign bypass    = head_load && ring_empty;
    assign ring_wr   = req_push && !bypass;
    assign ring_rd   = head_load && !ring_empty;

    always_ff @(posedge aclk)
    begin
        if (ring_wr)
        begin
            ring[wr_ptr[LG-1:0]] <= push_entry;
        end
        if (ring_rd)
        begin
            head_q <= ring[rd_ptr[LG-1:0]];
        end
        else if (bypass && req_push)
        begin
            head_q <= push_entry;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            head_valid <= 1'b0;
        end
        else
        begin
            if (ring_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ring_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (head_load)
            begin
                head_valid <= !ring_empty || req_push;
            end
        end
    end

    assign req_valid   = head_valid;
    assign head_commit = head_q.commit;
    assign head_addr   = head_q.addr;
    assign head_data   = head_q.data;
    assign head_vsync  = head_q.vsync;

endmodule

// ==== hdl/rix_fb_writer.sv ====
// Framebuffer writer
// Issues one memory write beat per pixel request, counts the
// pending write responses and runs the buffer swap handshake
`timescale 1ns/1ps
`include "rix_cfg.svh"

module rix_fb_writer
(
    input  logic                    aclk,
    input  logic                    rst_n,

    input  logic                    req_valid,
    output logic                    req_pop,
    input  logic                    head_commit,
    input  rix_mem_pkg::mem_addr_t  head_addr,
    input  rix_mem_pkg::mem_data_t  head_data,
    input  logic                    head_vsync,

    output logic                    mem_wvalid,
    input  logic                    mem_wready,
    output rix_mem_pkg::mem_addr_t  mem_waddr,
    output rix_mem_pkg::mem_data_t  mem_wdata,
    input  logic                    mem_bvalid,

    output logic                    swap_fb,
    output logic                    swap_fb_enable_vsync,
    output rix_mem_pkg::mem_addr_t  fb_addr,
    input  logic                    fb_swapped
);
    localparam int CNT_W = $clog2(`RIX_MAX_OUTSTANDING + 1);

    logic [CNT_W - 1 : 0]   pending_cnt;
    logic [CNT_W : 0]       in_flight;
    logic                   wr_accept;
    logic                   wr_load;
    logic                   swap_start;
    logic                   swap_done;

    // Writes issued but not yet answered, including a beat still
    // waiting in the output register
    assign in_flight = pending_cnt + mem_wvalid;
    assign wr_accept = mem_wvalid && mem_wready;

    assign wr_load = req_valid && !head_commit
                     && (!mem_wvalid || mem_wready)
                     && (in_flight < `RIX_MAX_OUTSTANDING);

    // Swap only once every earlier write has its response
    assign swap_start = req_valid && head_commit && !swap_fb && (in_flight == '0);
    assign swap_done  = swap_fb && fb_swapped;

    assign req_pop = wr_load || swap_done;

    always_ff @(posedge aclk)
    begin
        if (wr_load)
        begin
            mem_waddr <= head_addr;
            mem_wdata <= head_data;
        end
        if (swap_start)
        begin
            fb_addr              <= head_addr;
            swap_fb_enable_vsync <= head_vsync;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            mem_wvalid  <= 1'b0;
            swap_fb     <= 1'b0;
            pending_cnt <= '0;
        end
        else
        begin
            if (wr_load)
            begin
                mem_wvalid <= 1'b1;
            end
            else if (wr_accept)
            begin
                mem_wvalid <= 1'b0;
            end

            case ({wr_accept, mem_bvalid})
                2'b10: pending_cnt <= pending_cnt + 1'b1;
                2'b01: pending_cnt <= pending_cnt - 1'b1;
                default: pending_cnt <= pending_cnt;
            endcase

            if (swap_start)
            begin
                swap_fb <= 1'b1;
            end
            else if (swap_done)
            begin
                swap_fb <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/rasterix_fb_top.sv ====
// Top level of the framebuffer write path
// Command parser, request FIFO and framebuffer writer
`timescale 1ns/1ps

module rasterix_fb_top
(
    input  logic                    aclk,
    input  logic                    rst_n,

    // Command stream
    input  logic                    s_cmd_tvalid,
    output logic                    s_cmd_tready,
    input  logic                    s_cmd_tlast,
    input  rix_mem_pkg::mem_data_t  s_cmd_tdata,

    // Memory write port
    output logic                    mem_wvalid,
    input  logic                    mem_wready,
    output rix_mem_pkg::mem_addr_t  mem_waddr,
    output rix_mem_pkg::mem_data_t  mem_wdata,
    input  logic                    mem_bvalid,

    // Buffer swap
    output logic                    swap_fb,
    output logic                    swap_fb_enable_vsync,
    output rix_mem_pkg::mem_addr_t  fb_addr,
    input  logic                    fb_swapped
);
    logic                   req_push;
    logic                   req_commit;
    rix_mem_pkg::mem_addr_t req_addr;
    rix_mem_pkg::mem_data_t req_data;
    logic                   req_vsync;
    logic                   req_full;
    logic                   req_valid;
    logic                   req_pop;
    logic                   head_commit;
    rix_mem_pkg::mem_addr_t head_addr;
    rix_mem_pkg::mem_data_t head_data;
    logic                   head_vsync;

    rix_cmd_parser u_cmd_parser
    (
        .aclk(aclk),
        .rst_n(rst_n),
        .s_cmd_tvalid(s_cmd_tvalid),
        .s_cmd_tready(s_cmd_tready),
        .s_cmd_tlast(s_cmd_tlast),
        .s_cmd_tdata(s_cmd_tdata),
        .req_full(req_full),
        .req_push(req_push),
        .req_commit(req_commit),
        .req_addr(req_addr),
        .req_data(req_data),
        .req_vsync(req_vsync)
    );

    rix_req_fifo u_req_fifo
    (
        .aclk(aclk),
        .rst_n(rst_n),
        .req_push(req_push),
        .req_commit(req_commit),
        .req_addr(req_addr),
        .req_data(req_data),
        .req_vsync(req_vsync),
        .req_full(req_full),
        .req_valid(req_valid),
        .req_pop(req_pop),
        .head_commit(head_commit),
        .head_addr(head_addr),
        .head_data(head_data),
        .head_vsync(head_vsync)
    );

    rix_fb_writer u_fb_writer
    (
        .aclk(aclk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req_pop(req_pop),
        .head_commit(head_commit),
        .head_addr(head_addr),
        .head_data(head_data),
        .head_vsync(head_vsync),
        .mem_wvalid(mem_wvalid),
        .mem_wready(mem_wready),
        .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata),
        .mem_bvalid(mem_bvalid),
        .swap_fb(swap_fb),
        .swap_fb_enable_vsync(swap_fb_enable_vsync),
        .fb_addr(fb_addr),
        .fb_swapped(fb_swapped)
    );

endmodule

// ==== test/rix_fb_assert.sv ====
// Concurrent checks on the framebuffer writer
// Stalled write beat stability, swap hold and the pending response limit
`timescale 1ns/1ps
`include "rix_cfg.svh"

module rix_fb_assert
(
    input logic                                             aclk,
    input logic                                             rst_n,
    input logic                                             mem_wvalid,
    input logic                                             mem_wready,
    input rix_mem_pkg::mem_addr_t                           mem_waddr,
    input rix_mem_pkg::mem_data_t                           mem_wdata,
    input logic                                             swap_fb,
    input logic                                             fb_swapped,
    input logic [$clog2(`RIX_MAX_OUTSTANDING + 1) - 1 : 0]  pending_cnt
);
    // A stalled beat keeps its address and data
    a_beat_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        (mem_wvalid && !mem_wready) |=> (mem_wvalid && $stable(mem_waddr) && $stable(mem_wdata)))
        else $error("write beat changed while mem_wready was low");

    a_swap_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        (swap_fb && !fb_swapped) |=> swap_fb)
        else $error("swap_fb dropped before fb_swapped");

    a_pending_limit: assert property (@(posedge aclk) disable iff (!rst_n)
        pending_cnt <= `RIX_MAX_OUTSTANDING)
        else $error("pending write responses above the limit");

endmodule

bind rix_fb_writer rix_fb_assert u_fb_assert
(
    .aclk(aclk),
    .rst_n(rst_n),
    .mem_wvalid(mem_wvalid),
    .mem_wready(mem_wready),
    .mem_waddr(mem_waddr),
    .mem_wdata(mem_wdata),
    .swap_fb(swap_fb),
    .fb_swapped(fb_swapped),
    .pending_cnt(pending_cnt)
);

// ==== test/tb_rasterix_fb.sv ====
// Testbench for the framebuffer write path
// Command table with a reference model, random memory responder,
// swap handshake checks and a watchdog
`timescale 1ns/1ps

module tb_rasterix_fb;
    localparam int NSTEP       = 32;
    localparam int BURST_START = 19;

    // Each row holds the command word and its tlast, then the expected fb_addr and vsync of a commit
    localparam logic [65:0] STEPS [NSTEP] = '{
        {32'h0000_0000, 1'b0, 32'h0, 1'b0},           // NOP
        {32'h1000_0000, 1'b0, 32'h0, 1'b0},           // SET_ADDR
        {32'h0001_0000, 1'b0, 32'h0, 1'b0},
        {32'h2000_0003, 1'b0, 32'h0, 1'b0},           // PIXELS, 3 words
        {32'hA000_0001, 1'b0, 32'h0, 1'b0},
        {32'hA000_0002, 1'b0, 32'h0, 1'b0},
        {32'hA000_0003, 1'b0, 32'h0, 1'b0},
        {32'h7000_0000, 1'b0, 32'h0, 1'b0},           // Unknown opcode
        {32'h2000_0002, 1'b0, 32'h0, 1'b0},           // Pointer carries over
        {32'hB000_0001, 1'b0, 32'h0, 1'b0},
        {32'hB000_0002, 1'b0, 32'h0, 1'b0},
        {32'h2000_0000, 1'b0, 32'h0, 1'b0},           // Zero count
        {32'h3000_0001, 1'b0, 32'h0001_0000, 1'b1},   // COMMIT with vsync
        {32'h1000_0000, 1'b0, 32'h0, 1'b0},
        {32'h0002_0000, 1'b0, 32'h0, 1'b0},
        {32'h2000_0005, 1'b0, 32'h0, 1'b0},           // Cut short by tlast
        {32'hC000_0001, 1'b0, 32'h0, 1'b0},
        {32'hC000_0002, 1'b1, 32'h0, 1'b0},
        {32'h2000_000C, 1'b0, 32'h0, 1'b0},           // Long block fills the FIFO
        {32'hD000_0001, 1'b0, 32'h0, 1'b0},
        {32'hD000_0002, 1'b0, 32'h0, 1'b0},
        {32'hD000_0003, 1'b0, 32'h0, 1'b0},
        {32'hD000_0004, 1'b0, 32'h0, 1'b0},
        {32'hD000_0005, 1'b0, 32'h0, 1'b0},
        {32'hD000_0006, 1'b0, 32'h0, 1'b0},
        {32'hD000_0007, 1'b0, 32'h0, 1'b0},
        {32'hD000_0008, 1'b0, 32'h0, 1'b0},
        {32'hD000_0009, 1'b0, 32'h0, 1'b0},
        {32'hD000_000A, 1'b0, 32'h0, 1'b0},
        {32'hD000_000B, 1'b0, 32'h0, 1'b0},
        {32'hD000_000C, 1'b1, 32'h0, 1'b0},
        {32'h3000_0000, 1'b0, 32'h0002_0000, 1'b0}    // COMMIT without vsync
    };

    logic aclk, rst_n, s_cmd_tvalid, s_cmd_tready, s_cmd_tlast;
    logic mem_wvalid, mem_wready, mem_bvalid, swap_fb, swap_fb_enable_vsync, fb_swapped;
    logic [31:0] s_cmd_tdata, mem_waddr, mem_wdata, fb_addr;

    logic [31:0] exp_addr_q[$], exp_data_q[$], swap_addr_q[$];
    logic        swap_vsync_q[$];
    int          swap_wcount_q[$], resp_q[$];
    int          errors, checks, writes_seen, exp_writes, cycle, swap_delay;
    logic        burst_hold, backpressure_seen, swap_busy;

    rasterix_fb_top u_rasterix_fb_top (.*);

    task automatic note_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    // Applies the command rules to the table and queues the expected writes and swaps
    task automatic build_model();
        logic [31:0] word;
        logic [31:0] ptr;
        int          remaining;
        int          state;    // 0 header, 1 address word, 2 pixel data
        int          nwrites;
        ptr = '0;
        remaining = 0;
        state = 0;
        nwrites = 0;
        for (int i = 0; i < NSTEP; i++)
        begin
            word = STEPS[i][65:34];
            if (state == 1)
            begin
                ptr = word;
                state = 0;
            end
            else if (state == 2)
            begin
                exp_addr_q.push_back(ptr);
                exp_data_q.push_back(word);
                nwrites++;
                ptr = ptr + 32'd4;
                remaining--;
                if ((remaining == 0) || STEPS[i][33])
                    state = 0;
            end
            else if (word[31:28] == rix_cmd_pkg::OP_SET_ADDR)
                state = 1;
            else if ((word[31:28] == rix_cmd_pkg::OP_PIXELS) && (word[15:0] != 16'd0))
            begin
                remaining = int'(word[15:0]);
                state = 2;
            end
            else if (word[31:28] == rix_cmd_pkg::OP_COMMIT)
            begin
                swap_addr_q.push_back(STEPS[i][32:1]);
                swap_vsync_q.push_back(STEPS[i][0]);
                swap_wcount_q.push_back(nwrites);
            end
        end
        exp_writes = nwrites;
    endtask

    // Presents one table word and returns on the falling edge after its acceptance
    task automatic send_word(input int idx);
        if ($urandom % 8 == 0)
        begin
            s_cmd_tvalid = 1'b0;
            repeat (1 + $urandom % 3) @(negedge aclk);
        end
        if (idx == BURST_START)
            burst_hold = 1'b1;
        s_cmd_tvalid = 1'b1;
        s_cmd_tdata  = STEPS[idx][65:34];
        s_cmd_tlast  = STEPS[idx][33];
        #1;
        while (!s_cmd_tready)
        begin
            // Only a stall inside the long block counts as FIFO back-pressure
            if (burst_hold)
                backpressure_seen = 1'b1;
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Memory and swap responder that drives and samples everything on the falling edge
    initial
    begin
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge aclk);
            cycle++;
            if (fb_swapped)
            begin
                fb_swapped = 1'b0;
                swap_busy  = 1'b0;
                compare_hex("swap_fb after fb_swapped", 32'h0, swap_fb);
            end
            else if (swap_fb && !swap_busy)
            begin
                if (swap_addr_q.size() == 0)
                    note_error("swap_fb was raised with no commit left in the command table");
                else
                begin
                    compare_hex("fb_addr", swap_addr_q.pop_front(), fb_addr);
                    compare_hex("swap_fb_enable_vsync", swap_vsync_q.pop_front(),
                                swap_fb_enable_vsync);
                    compare_hex("writes before swap_fb", swap_wcount_q.pop_front(), writes_seen);
                end
                if (resp_q.size() != 0)
                    note_error("swap_fb rose while write responses were still outstanding");
                swap_busy  = 1'b1;
                swap_delay = $urandom % 4;
            end
            else if (swap_busy)
            begin
                if (swap_delay == 0)
                    fb_swapped = 1'b1;
                else
                    swap_delay--;
            end

            mem_bvalid = 1'b0;
            if ((resp_q.size() != 0) && (resp_q[0] <= cycle))
            begin
                mem_bvalid = 1'b1;
                void'(resp_q.pop_front());
            end

            // Held low at the start of the long block until the stream stalls
            if (burst_hold && !backpressure_seen)
                mem_wready = 1'b0;
            else
                mem_wready = ($urandom % 2 == 0);

            if (mem_wvalid && mem_wready)
            begin
                writes_seen++;
                if (exp_addr_q.size() == 0)
                    note_error($sformatf("unexpected memory write at address %h", mem_waddr));
                else
                begin
                    compare_hex("mem_waddr", exp_addr_q.pop_front(), mem_waddr);
                    compare_hex("mem_wdata", exp_data_q.pop_front(), mem_wdata);
                end
                resp_q.push_back(cycle + 1 + int'($urandom % 8));
            end
        end
    end

    initial
    begin
        repeat (NSTEP * 64) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", NSTEP * 64);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        void'($urandom(60));
        rst_n = 1'b0;
        s_cmd_tvalid = 1'b0;
        s_cmd_tlast = 1'b0;
        s_cmd_tdata = '0;
        mem_wready = 1'b0;
        mem_bvalid = 1'b0;
        fb_swapped = 1'b0;
        burst_hold = 1'b0;
        backpressure_seen = 1'b0;
        swap_busy = 1'b0;
        build_model();
        repeat (7) @(negedge aclk);
        compare_hex("mem_wvalid in reset", 32'h0, mem_wvalid);
        compare_hex("swap_fb in reset", 32'h0, swap_fb);
        compare_hex("s_cmd_tready in reset", 32'h0, s_cmd_tready);
        @(negedge aclk);
        rst_n = 1'b1;

        for (int i = 0; i < NSTEP; i++)
            send_word(i);
        s_cmd_tvalid = 1'b0;
        s_cmd_tlast  = 1'b0;

        while ((exp_addr_q.size() != 0) || (swap_addr_q.size() != 0) || swap_busy ||
               (resp_q.size() != 0))
            @(negedge aclk);
        repeat (20) @(negedge aclk);

        compare_hex("memory write count", exp_writes, writes_seen);
        if (!backpressure_seen)
            note_error("s_cmd_tready never dropped while the request FIFO was full");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/rix_cmd_pkg.sv
hdl/rix_mem_pkg.sv
hdl/rix_cmd_parser.sv
hdl/rix_req_fifo.sv
hdl/rix_fb_writer.sv
hdl/rasterix_fb_top.sv
test/rix_fb_assert.sv
test/tb_rasterix_fb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the framebuffer path with its testbench in Verilator, run it, then scan the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rasterix_fb \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"
grep -q "PASS: all tests" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
